/* design/ant_pkg.sv */
`default_nettype none

package ant_pkg;

    // Ant record field widths
    localparam int X_COORD_WIDTH = 8;
    localparam int Y_COORD_WIDTH = 7;
    localparam int FITNESS_WIDTH = 16;

    // Datapath and memory
    localparam int RESULT_WIDTH     = 16;
    localparam int MEM_ADDR_WIDTH   = 10;
    localparam int ANT_ID_WIDTH     = 8;
    localparam int ANT_RECORD_WORDS = 4;

    // Neural network sizes
    localparam int NN_DATA_WIDTH = 8;
    localparam int NN_INPUTS     = 8;
    localparam int NN_OUTPUTS    = 4;
    // Eight 16-bit signed products need three extra bits
    localparam int NN_SUM_WIDTH  = 19;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_MEMREAD,
        OP_MEMWRITE
    } dp_opcode_e;

    // Field number within an ant record
    typedef enum logic [1:0] {
        FIELD_X       = 2'd0,
        FIELD_Y       = 2'd1,
        FIELD_FITNESS = 2'd2
    } ant_field_e;

    typedef enum logic [3:0] {
        STANDBY,
        ISSUE,
        HOLD,
        WAIT,
        THINK,
        MOVE
    } ant_state_e;

    typedef logic signed [NN_DATA_WIDTH-1:0] nn_data_t;
    typedef logic [ANT_ID_WIDTH-1:0] ant_id_t;

    typedef struct packed {
        logic [RESULT_WIDTH-1:0]   data;
        logic [MEM_ADDR_WIDTH-1:0] addr;
        dp_opcode_e                opcode;
    } dp_instr_t;

    // Viewed as an array, element 7 is food_left and element 0 is poison_down
    typedef struct packed {
        nn_data_t food_left;
        nn_data_t food_right;
        nn_data_t food_up;
        nn_data_t food_down;
        nn_data_t poison_left;
        nn_data_t poison_right;
        nn_data_t poison_up;
        nn_data_t poison_down;
    } sense_vec_t;

    // Row 0 left, 1 right, 2 up, 3 down; each row laid out like sense_vec_t
    typedef nn_data_t [NN_OUTPUTS-1:0][NN_INPUTS-1:0] nn_weights_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } move_t;

endpackage

`default_nettype wire

/* design/nn_neuron.sv */
`timescale 1ns/1ps
`default_nettype none

module nn_neuron (
    input  logic                                         clock,
    input  logic                                         resetn,
    input  ant_pkg::sense_vec_t                          senses,
    input  ant_pkg::nn_data_t [ant_pkg::NN_INPUTS-1:0]   weight_row,
    output logic                                         fire
);
    import ant_pkg::*;

    nn_data_t [NN_INPUTS-1:0]       sense_arr;
    logic signed [NN_SUM_WIDTH-1:0] sum;

    // Same bit layout as the struct, element 7 is food_left
    assign sense_arr = senses;

    always_comb begin
        sum = '0;
        for (int i = 0; i < NN_INPUTS; i++) begin
            sum += NN_SUM_WIDTH'(signed'(sense_arr[i]) * signed'(weight_row[i]));
        end
    end

    // Fires on a strictly positive sum
    always_ff @(posedge clock) begin
        if (!resetn) begin
            fire <= 1'b0;
        end else begin
            fire <= (sum > 0);
        end
    end

endmodule

`default_nettype wire

/* design/ant_brain.sv */
`timescale 1ns/1ps
`default_nettype none

module ant_brain (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 sense_load,
    input  ant_pkg::sense_vec_t  senses,
    input  ant_pkg::nn_weights_t weights,
    output ant_pkg::move_t       move
);
    import ant_pkg::*;

    sense_vec_t            sense_q;
    logic [NN_OUTPUTS-1:0] fire;

    // Hold the readings steady for the neurons
    always_ff @(posedge clock) begin
        if (sense_load) begin
            sense_q <= senses;
        end
    end

    for (genvar g = 0; g < NN_OUTPUTS; g++) begin : g_neuron
        nn_neuron i_nn_neuron (
            .clock      (clock),
            .resetn     (resetn),
            .senses     (sense_q),
            .weight_row (weights[g]),
            .fire       (fire[g])
        );
    end

    // Neuron index follows the weight row order
    assign move.left  = fire[0];
    assign move.right = fire[1];
    assign move.up    = fire[2];
    assign move.down  = fire[3];

endmodule

`default_nettype wire

/* design/ant_update_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ant_update_ctrl (
    input  logic                              clock,
    input  logic                              resetn,
    input  logic                              start,
    output logic                              finished,

    input  ant_pkg::ant_id_t                  id,

    input  logic                              finished_dp,
    input  logic [ant_pkg::RESULT_WIDTH-1:0]  result_dp,
    output logic                              start_dp,
    output ant_pkg::dp_instr_t                instruction_dp,

    output logic                              sense_load,
    input  ant_pkg::move_t                    move
);
    import ant_pkg::*;

    ant_state_e state;
    ant_field_e field;
    // Low while reading the record, high while writing it back
    logic       is_write;
    logic       think_cnt;

    logic [X_COORD_WIDTH-1:0] x;
    logic [Y_COORD_WIDTH-1:0] y;
    logic [FITNESS_WIDTH-1:0] fitness;

    logic [RESULT_WIDTH-1:0] write_data;

    // Engine is idle exactly when it sits in STANDBY
    assign finished = (state == STANDBY);

    // Start strobe spans the ISSUE and HOLD cycles
    assign start_dp = (state == ISSUE) || (state == HOLD);

    always_comb begin
        unique case (field)
            FIELD_X:       write_data = RESULT_WIDTH'(x);
            FIELD_Y:       write_data = RESULT_WIDTH'(y);
            FIELD_FITNESS: write_data = RESULT_WIDTH'(fitness);
            default:       write_data = '0;
        endcase
    end

    // Instruction is built from registers that stay put while start_dp is high
    always_comb begin
        instruction_dp.addr   = MEM_ADDR_WIDTH'(id * ANT_RECORD_WORDS + field);
        instruction_dp.data   = '0;
        instruction_dp.opcode = OP_NOP;
        if (start_dp) begin
            if (is_write) begin
                instruction_dp.opcode = OP_MEMWRITE;
                instruction_dp.data   = write_data;
            end else begin
                instruction_dp.opcode = OP_MEMREAD;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state      <= STANDBY;
            field      <= FIELD_X;
            is_write   <= 1'b0;
            think_cnt  <= 1'b0;
            sense_load <= 1'b0;
        end else begin
            sense_load <= 1'b0;
            unique case (state)
                STANDBY: begin
                    if (start) begin
                        field    <= FIELD_X;
                        is_write <= 1'b0;
                        state    <= ISSUE;
                    end
                end
                ISSUE: begin
                    state <= HOLD;
                end
                HOLD: begin
                    state <= WAIT;
                end
                WAIT: begin
                    if (finished_dp) begin
                        if (field == FIELD_FITNESS) begin
                            field <= FIELD_X;
                            if (is_write) begin
                                state <= STANDBY;
                            end else begin
                                // All three fields read, hand senses to the brain
                                state      <= THINK;
                                think_cnt  <= 1'b0;
                                sense_load <= 1'b1;
                            end
                        end else begin
                            field <= ant_field_e'(field + 2'd1);
                            state <= ISSUE;
                        end
                    end
                end
                THINK: begin
                    // One cycle for the sense latch, one for the neurons
                    if (think_cnt) begin
                        state <= MOVE;
                    end else begin
                        think_cnt <= 1'b1;
                    end
                end
                MOVE: begin
                    is_write <= 1'b1;
                    state    <= ISSUE;
                end
                default: begin
                    state <= STANDBY;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == WAIT && finished_dp && !is_write) begin
            unique case (field)
                FIELD_X:       x       <= result_dp[X_COORD_WIDTH-1:0];
                FIELD_Y:       y       <= result_dp[Y_COORD_WIDTH-1:0];
                FIELD_FITNESS: fitness <= result_dp[FITNESS_WIDTH-1:0];
                default:       ;
            endcase
        end
        // Opposite fire bits cancel, coordinates wrap at the field width
        if (state == MOVE) begin
            x <= x + X_COORD_WIDTH'(move.right) - X_COORD_WIDTH'(move.left);
            y <= y + Y_COORD_WIDTH'(move.down) - Y_COORD_WIDTH'(move.up);
        end
    end

endmodule

`default_nettype wire

/* design/ant_update.sv */
`timescale 1ns/1ps
`default_nettype none

module ant_update (
    input  logic                              clock,
    input  logic                              resetn,
    input  logic                              start,
    output logic                              finished,

    input  ant_pkg::ant_id_t                  id,
    input  ant_pkg::sense_vec_t               senses,
    input  ant_pkg::nn_weights_t              weights,

    input  logic                              finished_dp,
    input  logic [ant_pkg::RESULT_WIDTH-1:0]  result_dp,
    output logic                              start_dp,
    output ant_pkg::dp_instr_t                instruction_dp
);
    import ant_pkg::*;

    logic  sense_load;
    move_t move;

    // Sequencer for the datapath transactions and the move
    ant_update_ctrl i_ant_update_ctrl (
        .clock          (clock),
        .resetn         (resetn),
        .start          (start),
        .finished       (finished),
        .id             (id),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .sense_load     (sense_load),
        .move           (move)
    );

    ant_brain i_ant_brain (
        .clock      (clock),
        .resetn     (resetn),
        .sense_load (sense_load),
        .senses     (senses),
        .weights    (weights),
        .move       (move)
    );

endmodule

`default_nettype wire

/* test/ant_update_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module ant_update_chk (
    input logic               clock,
    input logic               resetn,
    input logic               start,
    input logic               finished,
    input logic               start_dp,
    input logic               finished_dp,
    input ant_pkg::dp_instr_t instruction_dp
);
    int unsigned fail_count = 0;
    logic        started;
    // A strobe has been sent and its reply has not come back yet
    logic        outstanding;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            started     <= 1'b0;
            outstanding <= 1'b0;
        end else begin
            if (start) begin
                started <= 1'b1;
            end
            if (start_dp) begin
                outstanding <= 1'b1;
            end else if (finished_dp) begin
                outstanding <= 1'b0;
            end
        end
    end

    a_idle_after_reset: assert property (@(posedge clock) disable iff (!resetn)
        !started |-> finished && !start_dp)
        else begin
            fail_count++;
            $error("engine not idle between reset and the first start");
        end

    a_strobe_second_cycle: assert property (@(posedge clock) disable iff (!resetn)
        $rose(start_dp) |=> start_dp)
        else begin
            fail_count++;
            $error("start_dp lasted only one cycle");
        end

    a_strobe_ends: assert property (@(posedge clock) disable iff (!resetn)
        start_dp && $past(start_dp) |=> !start_dp)
        else begin
            fail_count++;
            $error("start_dp lasted more than two cycles");
        end

    a_instr_stable: assert property (@(posedge clock) disable iff (!resetn)
        start_dp && $past(start_dp) |-> $stable(instruction_dp))
        else begin
            fail_count++;
            $error("instruction_dp changed during start_dp");
        end

    a_no_early_strobe: assert property (@(posedge clock) disable iff (!resetn)
        outstanding && !start_dp && !finished_dp |=> !start_dp)
        else begin
            fail_count++;
            $error("new start_dp before finished_dp");
        end

endmodule

`default_nettype wire

/* test/ant_update_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ant_update_tb;
    import ant_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_ANTS       = 40;
    localparam int CYCLES_PER_ANT = 200;
    localparam int MAX_DP_DELAY   = 6;
    localparam int ROW_BITS       = NN_INPUTS * NN_DATA_WIDTH;

    logic                    clock;
    logic                    resetn;
    logic                    start;
    logic                    finished;
    ant_id_t                 id;
    sense_vec_t              senses;
    nn_weights_t             weights;
    logic                    finished_dp;
    logic [RESULT_WIDTH-1:0] result_dp;
    logic                    start_dp;
    dp_instr_t               instruction_dp;

    logic [RESULT_WIDTH-1:0] mem [0:(1 << MEM_ADDR_WIDTH)-1];
    dp_instr_t               txn_log [$];
    int                      errors;
    int unsigned             protocol_errors;

    ant_update i_ant_update (
        .clock          (clock),
        .resetn         (resetn),
        .start          (start),
        .finished       (finished),
        .id             (id),
        .senses         (senses),
        .weights        (weights),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp)
    );

    bind ant_update ant_update_chk i_ant_update_chk (
        .clock          (clock),
        .resetn         (resetn),
        .start          (start),
        .finished       (finished),
        .start_dp       (start_dp),
        .finished_dp    (finished_dp),
        .instruction_dp (instruction_dp)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic report_mismatch(string what, int got, int expected);
        errors++;
        $display("** Error %0t: %s is %0d, expected %0d", $time, what, got, expected);
    endtask

    function automatic int product(nn_data_t a, nn_data_t b);
        return int'(a) * int'(b);
    endfunction

    // Weight row viewed with the same field names as the senses
    function automatic int weighted_sum(sense_vec_t s, sense_vec_t w);
        return product(s.food_left, w.food_left) + product(s.food_right, w.food_right)
             + product(s.food_up, w.food_up) + product(s.food_down, w.food_down)
             + product(s.poison_left, w.poison_left) + product(s.poison_right, w.poison_right)
             + product(s.poison_up, w.poison_up) + product(s.poison_down, w.poison_down);
    endfunction

    // Memory behind the datapath that replies after a random number of cycles
    task automatic serve_datapath();
        dp_instr_t instr;
        int        delay;
        forever begin
            @(posedge clock);
            #1;
            finished_dp = 1'b0;
            result_dp   = RESULT_WIDTH'($urandom);
            if (start_dp) begin
                instr = instruction_dp;
                delay = $urandom_range(0, MAX_DP_DELAY);
                // Both strobe cycles pass before any reply
                repeat (2 + delay) begin
                    @(posedge clock);
                    #1;
                end
                txn_log.push_back(instr);
                if (instr.opcode == OP_MEMWRITE) begin
                    mem[instr.addr] = instr.data;
                end else begin
                    result_dp = mem[instr.addr];
                end
                finished_dp = 1'b1;
            end
        end
    endtask

    task automatic run_ant(int n);
        ant_id_t                        aid;
        logic [X_COORD_WIDTH-1:0]       x0;
        logic [X_COORD_WIDTH-1:0]       x_exp;
        logic [Y_COORD_WIDTH-1:0]       y0;
        logic [Y_COORD_WIDTH-1:0]       y_exp;
        logic [FITNESS_WIDTH-1:0]       fit0;
        logic [NN_OUTPUTS*ROW_BITS-1:0] wbits;
        logic [7:0]                     lsb;
        logic [NN_OUTPUTS-1:0]          fires;
        logic [MEM_ADDR_WIDTH-1:0]      base;
        sense_vec_t                     row;
        dp_opcode_e                     exp_op;
        int                             dx;
        int                             dy;

        aid    = ant_id_t'($urandom);
        x0     = X_COORD_WIDTH'($urandom);
        y0     = Y_COORD_WIDTH'($urandom);
        fit0   = FITNESS_WIDTH'($urandom);
        senses = {$urandom, $urandom};
        wbits  = {$urandom, $urandom, $urandom, $urandom,
                  $urandom, $urandom, $urandom, $urandom};
        // Edge ants sit at 0 or at the top and get pushed across the wrap
        if (n % 4 == 1 || n % 4 == 2) begin
            x0     = (n % 4 == 1) ? '0 : '1;
            y0     = (n % 4 == 1) ? '0 : '1;
            senses = senses & {8{8'h7f}};
            for (int k = 0; k < NN_OUTPUTS; k++) begin
                lsb = 8'(k * ROW_BITS);
                if ((k % 2 == 0) == (n % 4 == 1)) begin
                    wbits[lsb +: ROW_BITS] = wbits[lsb +: ROW_BITS] & {8{8'h7f}};
                end else begin
                    wbits[lsb +: ROW_BITS] = wbits[lsb +: ROW_BITS] | {8{8'h80}};
                end
            end
        end
        weights = nn_weights_t'(wbits);

        base = MEM_ADDR_WIDTH'(int'(aid) * ANT_RECORD_WORDS);
        mem[base + MEM_ADDR_WIDTH'(FIELD_X)]       = RESULT_WIDTH'(x0);
        mem[base + MEM_ADDR_WIDTH'(FIELD_Y)]       = RESULT_WIDTH'(y0);
        mem[base + MEM_ADDR_WIDTH'(FIELD_FITNESS)] = RESULT_WIDTH'(fit0);

        // Rows in order left, right, up, down
        for (int k = 0; k < NN_OUTPUTS; k++) begin
            row             = weights[2'(k)];
            fires[2'(k)]    = weighted_sum(senses, row) > 0;
        end
        // Right and down count up, left and up count down, modulo the coordinate range
        dx    = int'(fires[1]) - int'(fires[0]);
        dy    = int'(fires[3]) - int'(fires[2]);
        x_exp = X_COORD_WIDTH'((int'(x0) + dx + (1 << X_COORD_WIDTH)) % (1 << X_COORD_WIDTH));
        y_exp = Y_COORD_WIDTH'((int'(y0) + dy + (1 << Y_COORD_WIDTH)) % (1 << Y_COORD_WIDTH));

        txn_log.delete();
        @(posedge clock);
        #1;
        id    = aid;
        start = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b0;
        assert (!finished) else report_mismatch("finished after start", int'(finished), 0);
        while (!finished) begin
            @(posedge clock);
            #1;
        end

        // All six replies must be in before finished rises
        assert (txn_log.size() == 6)
            else report_mismatch("transaction count", txn_log.size(), 6);
        for (int t = 0; t < txn_log.size() && t < 6; t++) begin
            if (t < 3) begin
                exp_op = OP_MEMREAD;
            end else begin
                exp_op = OP_MEMWRITE;
            end
            assert (txn_log[t].opcode == exp_op)
                else report_mismatch("opcode", int'(txn_log[t].opcode), int'(exp_op));
            assert (int'(txn_log[t].addr) == int'(aid) * ANT_RECORD_WORDS + t % 3)
                else report_mismatch("address", int'(txn_log[t].addr),
                                     int'(aid) * ANT_RECORD_WORDS + t % 3);
        end
        if (txn_log.size() == 6) begin
            assert (txn_log[3].data == RESULT_WIDTH'(x_exp))
                else report_mismatch("X written", int'(txn_log[3].data), int'(x_exp));
            assert (txn_log[4].data == RESULT_WIDTH'(y_exp))
                else report_mismatch("Y written", int'(txn_log[4].data), int'(y_exp));
            assert (txn_log[5].data == fit0)
                else report_mismatch("fitness written", int'(txn_log[5].data), int'(fit0));
        end
    endtask

    initial begin
        void'($urandom(32'he619_c810));
        clock       = 1'b0;
        resetn      = 1'b0;
        start       = 1'b0;
        id          = '0;
        senses      = '0;
        weights     = '0;
        finished_dp = 1'b0;
        result_dp   = '0;
        errors      = 0;
        for (int a = 0; a < (1 << MEM_ADDR_WIDTH); a++) begin
            mem[MEM_ADDR_WIDTH'(a)] = RESULT_WIDTH'(a * 40503) ^ 16'h5a5a;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        resetn = 1'b1;
        fork
            serve_datapath();
        join_none
        for (int n = 0; n < NUM_ANTS; n++) begin
            run_ant(n);
        end
        protocol_errors = i_ant_update.i_ant_update_chk.fail_count;
        $display("Errors: %0d value, %0d protocol", errors, protocol_errors);
        if (errors == 0 && protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog sized for every ant at its worst case
    initial begin
        #(NUM_ANTS * CYCLES_PER_ANT * CLK_PERIOD);
        $display("Timeout: the engine hung and finished did not return in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
design/ant_pkg.sv
design/nn_neuron.sv
design/ant_brain.sv
design/ant_update_ctrl.sv
design/ant_update.sv
test/ant_update_chk.sv
test/ant_update_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ant_update_tb -f sim.f -o ant_update_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/ant_update_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^SIMULATION PASSED$"; then
    exit 0
fi
exit 1
